// ==== hw/alu8.sv ====
`default_nettype none

module alu8 (
	input wire [3:0] i_op, // {inr/dcr, alu op}
	input wire [cpu_pkg::DATA_W-1:0] i_a,
	input wire [cpu_pkg::DATA_W-1:0] i_b,
	input wire [cpu_pkg::DATA_W-1:0] i_flags,
	output logic [cpu_pkg::DATA_W-1:0] o_result,
	output logic [cpu_pkg::DATA_W-1:0] o_flags
);

	isa_pkg::alu_op_e op;
	logic keep_c; // inr/dcr leave carry alone
	logic cin;
	logic [cpu_pkg::DATA_W:0] sum; // top bit is carry
	logic [cpu_pkg::DATA_W:0] diff; // top bit is borrow
	logic [cpu_pkg::DATA_W-1:0] val; // value the flags are taken from
	logic cy;
	logic [cpu_pkg::DATA_W-1:0] fl;

	assign op = isa_pkg::alu_op_e'(i_op[2:0]);
	assign keep_c = i_op[3];

	always_comb begin
		cin = i_flags[isa_pkg::FLAG_C] & ((op == isa_pkg::ADC) | (op == isa_pkg::SBB));
		sum = {1'b0, i_a} + {1'b0, i_b} + {{cpu_pkg::DATA_W{1'b0}}, cin};
		diff = {1'b0, i_a} - {1'b0, i_b} - {{cpu_pkg::DATA_W{1'b0}}, cin};
		val = sum[cpu_pkg::DATA_W-1:0];
		cy = sum[cpu_pkg::DATA_W];
		case (op)
			isa_pkg::ADD, isa_pkg::ADC: begin
				val = sum[cpu_pkg::DATA_W-1:0];
				cy = sum[cpu_pkg::DATA_W];
			end
			isa_pkg::SUB, isa_pkg::SBB, isa_pkg::CMP: begin
				val = diff[cpu_pkg::DATA_W-1:0];
				cy = diff[cpu_pkg::DATA_W]; // borrow
			end
			isa_pkg::ANA: begin
				val = i_a & i_b;
				cy = 1'b0; // logic ops clear carry
			end
			isa_pkg::XRA: begin
				val = i_a ^ i_b;
				cy = 1'b0;
			end
			isa_pkg::ORA: begin
				val = i_a | i_b;
				cy = 1'b0;
			end
			default: ;
		endcase
		if (keep_c)
			cy = i_flags[isa_pkg::FLAG_C];
		o_result = (op == isa_pkg::CMP) ? i_a : val; // cmp only sets flags
		fl = '0;
		fl[isa_pkg::FLAG_S] = val[cpu_pkg::DATA_W-1];
		fl[isa_pkg::FLAG_Z] = (val == '0);
		fl[isa_pkg::FLAG_P] = ~^val; // even parity
		fl[isa_pkg::FLAG_C] = cy;
		o_flags = fl & isa_pkg::FLAG_MASK;
	end

endmodule

`default_nettype wire

// ==== hw/bus_cycle_ctrl.sv ====
`default_nettype none

module bus_cycle_ctrl (
	input wire clk,
	input wire rst,
	input wire i_ready,
	input wire [cpu_pkg::CYC_W-1:0] i_extra_cycles,
	input wire [cpu_pkg::MAX_EXTRA-1:0] i_write_mask,
	input wire i_halt,
	input wire [cpu_pkg::ADDR_W-1:0] i_addr,
	input wire [cpu_pkg::DATA_W-1:0] i_wdata,
	output logic o_ir_load,
	output logic [cpu_pkg::CYC_W-1:0] o_cycle_idx,
	output logic o_data_strobe,
	output logic o_exec,
	output logic [cpu_pkg::ADDR_W-cpu_pkg::DATA_W-1:0] o_addr_hi,
	output logic [cpu_pkg::DATA_W-1:0] o_ad,
	output logic o_ad_oe,
	output logic o_ale,
	output logic o_rd_n,
	output logic o_wr_n,
	output logic o_io_m_n,
	output logic o_s1,
	output logic o_s0
);

	cpu_pkg::t_state_e state_q, state_nxt;
	logic [cpu_pkg::CYC_W-1:0] idx_q, idx_nxt; // 0 = fetch
	cpu_pkg::cycle_e cyc_q, cyc_nxt;
	logic [2**cpu_pkg::CYC_W-1:0] wmask_ext; // write flag by cycle index
	logic last_cyc;
	logic strobe_act;
	logic rd_act;
	logic wr_act;
	logic [2:0] stat;

	always_comb begin
		wmask_ext = '0;
		wmask_ext[cpu_pkg::MAX_EXTRA:1] = i_write_mask; // fetch never writes
	end

	assign last_cyc = (idx_q == i_extra_cycles);

	// ------------------------------
	// t-state sequencing
	// ------------------------------
	always_comb begin
		state_nxt = state_q;
		idx_nxt = idx_q;
		case (state_q)
			cpu_pkg::TR: state_nxt = cpu_pkg::T1; // first fetch at pc 0
			cpu_pkg::T1: state_nxt = cpu_pkg::T2;
			cpu_pkg::T2, cpu_pkg::TW:
				state_nxt = i_ready ? cpu_pkg::T3 : cpu_pkg::TW; // stretch while not ready
			cpu_pkg::T3: begin
				if (idx_q == '0) begin
					state_nxt = cpu_pkg::T4; // decode needs the new ir
				end else begin
					state_nxt = cpu_pkg::T1;
					idx_nxt = last_cyc ? '0 : idx_q + 1'b1;
				end
			end
			cpu_pkg::T4: begin
				if (i_halt) begin
					state_nxt = cpu_pkg::TT;
				end else begin
					state_nxt = cpu_pkg::T1;
					idx_nxt = last_cyc ? '0 : idx_q + 1'b1; // 0 or first extra
				end
			end
			cpu_pkg::TT: state_nxt = cpu_pkg::TT; // only reset leaves
			default: state_nxt = cpu_pkg::TR;
		endcase
	end

	// kind of the cycle about to start
	always_comb begin
		if (state_nxt == cpu_pkg::TT)
			cyc_nxt = cpu_pkg::HLT;
		else if (idx_nxt == '0)
			cyc_nxt = cpu_pkg::OF;
		else
			cyc_nxt = wmask_ext[idx_nxt] ? cpu_pkg::MW : cpu_pkg::MR;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= cpu_pkg::TR;
			idx_q <= '0;
			cyc_q <= cpu_pkg::HLT; // status 000 in reset
		end else begin
			state_q <= state_nxt;
			idx_q <= idx_nxt;
			if (state_nxt == cpu_pkg::T1 || state_nxt == cpu_pkg::TT)
				cyc_q <= cyc_nxt; // status changes only at t1
		end
	end

	// ------------------------------
	// status and strobes
	// ------------------------------
	always_comb begin
		case (cyc_q)
			cpu_pkg::OF: stat = cpu_pkg::STAT_OF;
			cpu_pkg::MR: stat = cpu_pkg::STAT_MR;
			cpu_pkg::MW: stat = cpu_pkg::STAT_MW;
			default: stat = cpu_pkg::STAT_HLT;
		endcase
	end

	assign {o_io_m_n, o_s1, o_s0} = stat;

	assign strobe_act = (state_q == cpu_pkg::T2) || (state_q == cpu_pkg::TW) ||
		(state_q == cpu_pkg::T3);
	assign rd_act = strobe_act && (cyc_q == cpu_pkg::OF || cyc_q == cpu_pkg::MR);
	assign wr_act = strobe_act && (cyc_q == cpu_pkg::MW);

	assign o_ale = (state_q == cpu_pkg::T1);
	assign o_rd_n = ~rd_act;
	assign o_wr_n = ~wr_act;
	assign o_ad_oe = o_ale || wr_act; // off while memory drives
	assign o_ad = o_ale ? i_addr[cpu_pkg::DATA_W-1:0] : i_wdata; // low addr, then data
	assign o_addr_hi = i_addr[cpu_pkg::ADDR_W-1:cpu_pkg::DATA_W];

	// ------------------------------
	// datapath timing
	// ------------------------------
	assign o_cycle_idx = idx_q;
	assign o_data_strobe = (state_q == cpu_pkg::T3);
	assign o_ir_load = o_data_strobe && (idx_q == '0);
	assign o_exec = ((state_q == cpu_pkg::T4) && (i_extra_cycles == '0)) ||
		(o_data_strobe && (idx_q != '0) && last_cyc);

endmodule

`default_nettype wire

// ==== hw/cpu85_top.sv ====
`default_nettype none

module cpu85_top (
	input wire clk,
	input wire rst,
	input wire i_ready,
	input wire [cpu_pkg::DATA_W-1:0] i_ad,
	output wire [cpu_pkg::ADDR_W-cpu_pkg::DATA_W-1:0] o_addr_hi,
	output wire [cpu_pkg::DATA_W-1:0] o_ad,
	output wire o_ad_oe,
	output wire o_ale,
	output wire o_rd_n,
	output wire o_wr_n,
	output wire o_io_m_n,
	output wire o_s1,
	output wire o_s0
);

	isa_pkg::op_class_e op_class;
	isa_pkg::alu_op_e alu_op;
	logic [2:0] dst, src;
	logic [cpu_pkg::CYC_W-1:0] extra_cycles, cycle_idx;
	logic [cpu_pkg::MAX_EXTRA-1:0] write_mask;
	logic halt, ir_load, data_strobe, exec;
	logic [cpu_pkg::ADDR_W-1:0] addr;
	logic [cpu_pkg::DATA_W-1:0] wdata;

	instr_decoder dec_i (
		.clk(clk),
		.rst(rst),
		.i_ir_load(ir_load),
		.i_ad(i_ad),
		.o_op_class(op_class),
		.o_alu_op(alu_op),
		.o_dst(dst),
		.o_src(src),
		.o_extra_cycles(extra_cycles),
		.o_write_mask(write_mask),
		.o_halt(halt)
	);

	// sequencer owns the external bus
	bus_cycle_ctrl seq_i (
		.clk(clk),
		.rst(rst),
		.i_ready(i_ready),
		.i_extra_cycles(extra_cycles),
		.i_write_mask(write_mask),
		.i_halt(halt),
		.i_addr(addr),
		.i_wdata(wdata),
		.o_ir_load(ir_load),
		.o_cycle_idx(cycle_idx),
		.o_data_strobe(data_strobe),
		.o_exec(exec),
		.o_addr_hi(o_addr_hi),
		.o_ad(o_ad),
		.o_ad_oe(o_ad_oe),
		.o_ale(o_ale),
		.o_rd_n(o_rd_n),
		.o_wr_n(o_wr_n),
		.o_io_m_n(o_io_m_n),
		.o_s1(o_s1),
		.o_s0(o_s0)
	);

	exec_datapath dp_i (
		.clk(clk),
		.rst(rst),
		.i_op_class(op_class),
		.i_alu_op(alu_op),
		.i_dst(dst),
		.i_src(src),
		.i_cycle_idx(cycle_idx),
		.i_data_strobe(data_strobe),
		.i_exec(exec),
		.i_ad(i_ad),
		.o_addr(addr),
		.o_wdata(wdata)
	);

endmodule

`default_nettype wire

// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// ------------------------------
	// bus widths
	// ------------------------------
	localparam int ADDR_W = 16; // full address
	localparam int DATA_W = 8; // data byte, also low address half

	// machine cycles after the opcode fetch
	localparam int MAX_EXTRA = 2; // jmp, jccc and mvi m need two
	localparam int CYC_W = $clog2(MAX_EXTRA + 1); // cycle index width

	// ------------------------------
	// t-states, one-hot
	// ------------------------------
	typedef enum logic [6:0] {
		TR = 7'b0000001, // reset
		T1 = 7'b0000010, // address out, ale
		T2 = 7'b0000100, // strobe low, ready sampled
		TW = 7'b0001000, // wait
		T3 = 7'b0010000, // data sampled
		T4 = 7'b0100000, // decode after fetch
		TT = 7'b1000000 // halt
	} t_state_e;

	// machine cycle kind
	typedef enum logic [1:0] {
		OF, // opcode fetch
		MR, // memory read
		MW, // memory write
		HLT // halted, bus idle
	} cycle_e;

	// status lines {io_m_n, s1, s0}
	localparam logic [2:0] STAT_OF = 3'b011;
	localparam logic [2:0] STAT_MR = 3'b010;
	localparam logic [2:0] STAT_MW = 3'b001;
	localparam logic [2:0] STAT_HLT = 3'b000;

endpackage

`default_nettype wire

// ==== hw/exec_datapath.sv ====
`default_nettype none

module exec_datapath (
	input wire clk,
	input wire rst,
	input wire isa_pkg::op_class_e i_op_class,
	input wire isa_pkg::alu_op_e i_alu_op,
	input wire [2:0] i_dst,
	input wire [2:0] i_src,
	input wire [cpu_pkg::CYC_W-1:0] i_cycle_idx,
	input wire i_data_strobe,
	input wire i_exec,
	input wire [cpu_pkg::DATA_W-1:0] i_ad,
	output logic [cpu_pkg::ADDR_W-1:0] o_addr,
	output logic [cpu_pkg::DATA_W-1:0] o_wdata
);

	logic [cpu_pkg::DATA_W-1:0] regs [0:7]; // by register code, slot m unused
	logic [cpu_pkg::DATA_W-1:0] flags_q;
	logic [cpu_pkg::ADDR_W-1:0] pc_q;
	logic [cpu_pkg::DATA_W-1:0] opnd_q; // imm byte or low target byte
	logic [cpu_pkg::DATA_W-1:0] src_val;
	logic [cpu_pkg::DATA_W-1:0] alu_a, alu_b, alu_res, alu_flags;
	logic [3:0] alu_op;
	logic incdec;
	logic use_pc;
	logic cond_ok;
	logic pc_load;
	logic wr_en, flags_wr;
	logic [2:0] wr_idx;
	logic [cpu_pkg::DATA_W-1:0] wr_val;

	assign src_val = regs[i_src];

	// ------------------------------
	// alu operands
	// ------------------------------
	assign incdec = (i_op_class == isa_pkg::INR) || (i_op_class == isa_pkg::DCR);
	assign alu_a = incdec ? regs[i_dst] : regs[isa_pkg::REG_A];
	assign alu_b = (i_op_class == isa_pkg::ALU_R) ? src_val :
		incdec ? cpu_pkg::DATA_W'(1) : i_ad; // m and imm from bus
	assign alu_op = {incdec, (i_op_class == isa_pkg::DCR) ? isa_pkg::SUB :
		(i_op_class == isa_pkg::INR) ? isa_pkg::ADD : i_alu_op};

	alu8 alu_i (
		.i_op(alu_op),
		.i_a(alu_a),
		.i_b(alu_b),
		.i_flags(flags_q),
		.o_result(alu_res),
		.o_flags(alu_flags)
	);

	// jccc condition from ccc field
	always_comb begin
		case (i_dst)
			3'd0: cond_ok = ~flags_q[isa_pkg::FLAG_Z]; // nz
			3'd1: cond_ok = flags_q[isa_pkg::FLAG_Z]; // z
			3'd2: cond_ok = ~flags_q[isa_pkg::FLAG_C]; // nc
			3'd3: cond_ok = flags_q[isa_pkg::FLAG_C]; // c
			3'd4: cond_ok = ~flags_q[isa_pkg::FLAG_P]; // po
			3'd5: cond_ok = flags_q[isa_pkg::FLAG_P]; // pe
			3'd6: cond_ok = ~flags_q[isa_pkg::FLAG_S]; // p
			default: cond_ok = flags_q[isa_pkg::FLAG_S]; // m
		endcase
	end

	// ------------------------------
	// address and write data
	// ------------------------------
	always_comb begin
		use_pc = 1'b0;
		if (i_cycle_idx == '0)
			use_pc = 1'b1; // fetch, class still from last opcode
		else
			case (i_op_class)
				isa_pkg::MVI_R, isa_pkg::ALU_I, isa_pkg::JMP, isa_pkg::JCC: use_pc = 1'b1;
				isa_pkg::MVI_M: use_pc = (i_cycle_idx == cpu_pkg::CYC_W'(1)); // imm, then hl
				default: use_pc = 1'b0; // m operand
			endcase
	end

	assign o_addr = use_pc ? pc_q : {regs[isa_pkg::REG_H], regs[isa_pkg::REG_L]};
	assign o_wdata = (i_op_class == isa_pkg::MVI_M) ? opnd_q : src_val;

	always_ff @(posedge clk) begin
		if (i_data_strobe && i_cycle_idx == cpu_pkg::CYC_W'(1))
			opnd_q <= i_ad;
	end

	// target takes the live high byte at the last t3
	assign pc_load = i_exec && ((i_op_class == isa_pkg::JMP) ||
		(i_op_class == isa_pkg::JCC && cond_ok));

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pc_q <= '0;
		else if (pc_load)
			pc_q <= {i_ad, opnd_q};
		else if (i_data_strobe && use_pc)
			pc_q <= pc_q + 1'b1; // past opcode or imm byte
	end

	// ------------------------------
	// register writeback
	// ------------------------------
	always_comb begin
		wr_en = 1'b0;
		flags_wr = 1'b0;
		wr_idx = i_dst;
		wr_val = i_ad; // mov r,m and mvi r
		if (i_exec)
			case (i_op_class)
				isa_pkg::MOV_RR: begin
					wr_en = 1'b1;
					wr_val = src_val;
				end
				isa_pkg::MOV_RM, isa_pkg::MVI_R: wr_en = 1'b1;
				isa_pkg::ALU_R, isa_pkg::ALU_M, isa_pkg::ALU_I: begin
					wr_en = 1'b1; // cmp returns a unchanged
					wr_idx = isa_pkg::REG_A;
					wr_val = alu_res;
					flags_wr = 1'b1;
				end
				isa_pkg::INR, isa_pkg::DCR: begin
					wr_en = 1'b1;
					wr_val = alu_res;
					flags_wr = 1'b1;
				end
				default: ;
			endcase
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			regs[wr_idx] <= wr_val;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			flags_q <= '0;
		else if (flags_wr)
			flags_q <= alu_flags;
	end

endmodule

`default_nettype wire

// ==== hw/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
	input wire clk,
	input wire rst,
	input wire i_ir_load, // t3 of opcode fetch
	input wire [cpu_pkg::DATA_W-1:0] i_ad,
	output isa_pkg::op_class_e o_op_class,
	output isa_pkg::alu_op_e o_alu_op,
	output logic [2:0] o_dst, // also ccc for jccc
	output logic [2:0] o_src,
	output logic [cpu_pkg::CYC_W-1:0] o_extra_cycles,
	output logic [cpu_pkg::MAX_EXTRA-1:0] o_write_mask, // bit 0 = first extra cycle
	output logic o_halt
);

	logic [cpu_pkg::DATA_W-1:0] ir_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ir_q <= '0; // nop
		else if (i_ir_load)
			ir_q <= i_ad;
	end

	assign o_dst = ir_q[5:3];
	assign o_src = ir_q[2:0];
	assign o_alu_op = isa_pkg::alu_op_e'(ir_q[5:3]);

	// ------------------------------
	// opcode to class
	// ------------------------------
	always_comb begin
		o_op_class = isa_pkg::NOP; // unsupported codes run as nop
		case (ir_q[7:6])
			2'b00: begin // mvi, inr, dcr
				if (o_src == 3'b110)
					o_op_class = (o_dst == isa_pkg::REG_M) ? isa_pkg::MVI_M : isa_pkg::MVI_R;
				else if (o_src == 3'b100 && o_dst != isa_pkg::REG_M)
					o_op_class = isa_pkg::INR;
				else if (o_src == 3'b101 && o_dst != isa_pkg::REG_M)
					o_op_class = isa_pkg::DCR;
			end
			2'b01: begin // moves, hlt in the m,m slot
				if (o_dst == isa_pkg::REG_M && o_src == isa_pkg::REG_M)
					o_op_class = isa_pkg::HLT;
				else if (o_dst == isa_pkg::REG_M)
					o_op_class = isa_pkg::MOV_MR;
				else if (o_src == isa_pkg::REG_M)
					o_op_class = isa_pkg::MOV_RM;
				else
					o_op_class = isa_pkg::MOV_RR;
			end
			2'b10: o_op_class = (o_src == isa_pkg::REG_M) ? isa_pkg::ALU_M : isa_pkg::ALU_R;
			default: begin // 11: immediates and jumps
				if (o_src == 3'b110)
					o_op_class = isa_pkg::ALU_I;
				else if (o_src == 3'b011 && o_dst == 3'b000)
					o_op_class = isa_pkg::JMP; // c3
				else if (o_src == 3'b010)
					o_op_class = isa_pkg::JCC;
			end
		endcase
	end

	// ------------------------------
	// machine cycle plan
	// ------------------------------
	always_comb begin
		o_extra_cycles = '0;
		o_write_mask = '0;
		case (o_op_class)
			isa_pkg::MVI_R, isa_pkg::ALU_I, isa_pkg::MOV_RM, isa_pkg::ALU_M:
				o_extra_cycles = cpu_pkg::CYC_W'(1); // one read
			isa_pkg::MOV_MR: begin
				o_extra_cycles = cpu_pkg::CYC_W'(1);
				o_write_mask = cpu_pkg::MAX_EXTRA'(1); // the extra cycle writes
			end
			isa_pkg::MVI_M: begin
				o_extra_cycles = cpu_pkg::CYC_W'(2);
				o_write_mask = cpu_pkg::MAX_EXTRA'(2); // read imm, then write
			end
			isa_pkg::JMP, isa_pkg::JCC:
				o_extra_cycles = cpu_pkg::CYC_W'(2); // low, high target byte
			default: ;
		endcase
	end

	assign o_halt = (o_op_class == isa_pkg::HLT);

endmodule

`default_nettype wire

// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	// ------------------------------
	// operation classes
	// ------------------------------
	typedef enum logic [3:0] {
		NOP,
		MOV_RR, // mov r,r
		MOV_RM, // mov r,m  register from memory
		MOV_MR, // mov m,r  memory from register
		MVI_R,
		MVI_M,
		ALU_R,
		ALU_M,
		ALU_I,
		INR,
		DCR,
		JMP,
		JCC,
		HLT
	} op_class_e;

	// alu op, opcode bits 5:3
	typedef enum logic [2:0] {ADD, ADC, SUB, SBB, ANA, XRA, ORA, CMP} alu_op_e;

	// register codes
	localparam logic [2:0] REG_H = 3'b100;
	localparam logic [2:0] REG_L = 3'b101;
	localparam logic [2:0] REG_M = 3'b110; // memory at hl
	localparam logic [2:0] REG_A = 3'b111;

	// flag bit positions
	localparam int FLAG_S = 7;
	localparam int FLAG_Z = 6;
	localparam int FLAG_P = 2;
	localparam int FLAG_C = 0;
	localparam logic [7:0] FLAG_MASK = 8'b1100_0101; // s z p c kept

endpackage

`default_nettype wire

// ==== list.f ====
hw/cpu_pkg.sv
hw/isa_pkg.sv
hw/alu8.sv
hw/instr_decoder.sv
hw/bus_cycle_ctrl.sv
hw/exec_datapath.sv
hw/cpu85_top.sv
verif/cpu85_properties.sv
verif/tb_cpu85.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cpu85 testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu85 \
	-f list.f -o sim_cpu85 > build.log 2>&1 \
	&& ./obj_dir/sim_cpu85 > sim.log 2>&1 \
	|| { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "^Simulation finished: PASS$" sim.log \
	&& echo "cpu85 simulation passed" \
	|| { echo "cpu85 simulation failed, see sim.log"; exit 1; }

// ==== verif/cpu85_properties.sv ====
`default_nettype none

module cpu85_properties (
	input wire clk,
	input wire rst,
	input wire rd_n,
	input wire wr_n,
	input wire ad_oe,
	input wire ale
);

	// ------------------------------
	// bus strobe rules
	// ------------------------------
	rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
		!(!rd_n && !wr_n)) // one strobe at a time
		else $error("RD and WR are low together");

	oe_vs_rd: assert property (@(posedge clk) disable iff (rst)
		!(ad_oe && !rd_n)) // memory owns the bus while reading
		else $error("o_ad_oe is high while RD is low");

	ale_vs_strobe: assert property (@(posedge clk) disable iff (rst)
		!(ale && (!rd_n || !wr_n)))
		else $error("ALE is high while a strobe is low");

endmodule

bind cpu85_top cpu85_properties props_i (
	.clk(clk),
	.rst(rst),
	.rd_n(o_rd_n),
	.wr_n(o_wr_n),
	.ad_oe(o_ad_oe),
	.ale(o_ale)
);

`default_nettype wire

// ==== verif/tb_cpu85.sv ====
`default_nettype none

module tb_cpu85;

	localparam int N_INSTR = 300; // all tests together, rounded up
	localparam int N_TESTS = 6;
	localparam int MAX_WAIT = 3; // two lfsr bits per wait count
	localparam int TIMEOUT = (N_INSTR * 10 * (1 + MAX_WAIT) + N_TESTS * 60) * 40;

	logic clk, rst, i_ready;
	logic [7:0] i_ad;
	wire [7:0] o_addr_hi, o_ad;
	wire o_ad_oe, o_ale, o_rd_n, o_wr_n, o_io_m_n, o_s1, o_s0;
	wire [2:0] stat = {o_io_m_n, o_s1, o_s0};

	cpu85_top dut_i (
		.clk(clk), .rst(rst), .i_ready(i_ready), .i_ad(i_ad),
		.o_addr_hi(o_addr_hi), .o_ad(o_ad), .o_ad_oe(o_ad_oe), .o_ale(o_ale),
		.o_rd_n(o_rd_n), .o_wr_n(o_wr_n), .o_io_m_n(o_io_m_n), .o_s1(o_s1), .o_s0(o_s0)
	);

	logic [7:0] mem [0:255];
	logic [7:0] lat_lo, lat_hi, wr_byte, prog_ptr;
	logic [2:0] cur_stat, first_stat;
	logic prev_rd, prev_wr, wait_en;
	int wait_left, wait_total, ale_cnt, fetch_cnt, wr_cnt, exp_n;
	logic [15:0] fetch_log [0:511];
	logic [15:0] wr_addr_log [0:63];
	logic [7:0] wr_data_log [0:63];
	logic [15:0] exp_wa [0:63];
	logic [7:0] exp_wd [0:63];
	logic [31:0] lfsr_q;
	int err_cnt, test_cnt, fail_cnt;
	logic [7:0] alu_a0, alu_c; // operands shared by both alu runs
	logic [7:0] alu_b [0:7];
	logic [7:0] alu_d [0:7];

	always #20 clk = ~clk;

	initial begin
		#(TIMEOUT);
		$display("the run timed out before all tests finished");
		$display("Simulation finished: FAIL");
		$finish;
	end

	// galois lfsr, one step per bit
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
			v = {v[6:0], lfsr_q[0]};
		end
		return v;
	endfunction

	task automatic check_eq(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp) begin
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	// ------------------------------
	// reference alu, {flags, result}
	// ------------------------------
	function automatic logic [15:0] ref_alu(input int op, input logic [7:0] a,
		input logic [7:0] b, input logic [7:0] f, input bit incdec);
		logic [8:0] w;
		logic cin, cy;
		logic [7:0] v, fl;
		cin = (op == 1 || op == 3) ? f[isa_pkg::FLAG_C] : 1'b0; // adc, sbb
		case (op)
			0, 1: w = {1'b0, a} + {1'b0, b} + {8'd0, cin};
			2, 3, 7: w = {1'b0, a} - {1'b0, b} - {8'd0, cin}; // bit 8 is borrow
			4: w = {1'b0, a & b};
			5: w = {1'b0, a ^ b};
			default: w = {1'b0, a | b};
		endcase
		v = w[7:0];
		cy = incdec ? f[isa_pkg::FLAG_C] : w[8];
		fl = '0;
		fl[isa_pkg::FLAG_S] = v[7];
		fl[isa_pkg::FLAG_Z] = (v == 8'd0);
		fl[isa_pkg::FLAG_P] = ~^v; // even parity
		fl[isa_pkg::FLAG_C] = cy;
		return {fl, (op == 7) ? a : v};
	endfunction

	function automatic bit cond_holds(input int ccc, input logic [7:0] f);
		case (ccc)
			0: return !f[isa_pkg::FLAG_Z];
			1: return f[isa_pkg::FLAG_Z];
			2: return !f[isa_pkg::FLAG_C];
			3: return f[isa_pkg::FLAG_C];
			4: return !f[isa_pkg::FLAG_P];
			5: return f[isa_pkg::FLAG_P];
			6: return !f[isa_pkg::FLAG_S];
			default: return f[isa_pkg::FLAG_S];
		endcase
	endfunction

	// ------------------------------
	// memory model and bus monitor
	// ------------------------------
	always @(posedge clk) begin
		#5;
		if (!rst) begin
			if (!o_wr_n) begin
				wr_byte = o_ad;
				check_eq(16'(o_ad_oe), 16'd1, "bus driven during write");
			end
			if (!prev_wr && o_wr_n) begin // write just ended
				wr_addr_log[wr_cnt] = {lat_hi, lat_lo};
				wr_data_log[wr_cnt] = wr_byte;
				mem[lat_lo] = wr_byte;
				wr_cnt++;
			end
			if (o_ale) begin
				if (ale_cnt == 0)
					first_stat = stat;
				check_eq(16'(o_ad_oe), 16'd1, "bus driven with ALE");
				lat_lo = o_ad;
				lat_hi = o_addr_hi;
				cur_stat = stat;
				ale_cnt++;
				if (stat == cpu_pkg::STAT_OF) begin
					fetch_log[fetch_cnt] = {o_addr_hi, o_ad};
					fetch_cnt++;
				end
			end else if (stat != cur_stat) begin
				if (stat == cpu_pkg::STAT_HLT)
					cur_stat = stat; // halt entry
				else
					check_eq(16'(stat), 16'(cur_stat), "status held until next T1");
			end
			i_ad = !o_rd_n ? mem[lat_lo] : 8'h00;
			if (wait_left > 0) begin
				check_eq(16'(o_rd_n & o_wr_n), 16'd0, "strobe held during wait");
				check_eq(16'(o_addr_hi), 16'(lat_hi), "address held during wait");
				wait_left--;
				wait_total++;
				if (wait_left == 0)
					i_ready = 1'b1;
			end else if (wait_en && ((!o_rd_n && prev_rd) || (!o_wr_n && prev_wr))) begin
				wait_left = int'(rand_bits(2)); // t2 of a new cycle
				i_ready = (wait_left == 0);
			end
			prev_rd = o_rd_n;
			prev_wr = o_wr_n;
		end
	end

	// ------------------------------
	// program helpers
	// ------------------------------
	task automatic begin_prog();
		int i;
		for (i = 0; i < 256; i++)
			mem[i] = 8'(i * 7 + 8'h13);
		prog_ptr = 8'd0;
		exp_n = 0;
		wait_en = 1'b0;
	endtask

	task automatic emit(input logic [7:0] b);
		mem[prog_ptr] = b;
		prog_ptr = prog_ptr + 8'd1;
	endtask

	task automatic emit_mvi(input int r, input logic [7:0] v);
		emit(8'(8'h06 + r * 8));
		emit(v);
	endtask

	task automatic expect_write(input logic [15:0] a, input logic [7:0] d);
		exp_wa[exp_n] = a;
		exp_wd[exp_n] = d;
		exp_n++;
	endtask

	task automatic run_prog();
		int ales;
		@(posedge clk);
		#2 rst = 1'b1;
		fetch_cnt = 0;
		wr_cnt = 0;
		ale_cnt = 0;
		wait_left = 0;
		wait_total = 0;
		cur_stat = cpu_pkg::STAT_HLT;
		prev_rd = 1'b1;
		prev_wr = 1'b1;
		i_ready = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		check_eq(16'({o_ale, o_rd_n, o_wr_n, o_ad_oe}), 16'b0110, "control pins in reset");
		rst = 1'b0;
		do begin
			@(posedge clk);
			#6;
		end while (!(ale_cnt > 0 && stat == cpu_pkg::STAT_HLT));
		ales = ale_cnt;
		repeat (50) @(posedge clk);
		#6;
		check_eq(16'(ale_cnt), 16'(ales), "ALE count after HLT");
		check_eq(16'(stat), 16'(cpu_pkg::STAT_HLT), "status while halted");
	endtask

	task automatic check_writes();
		int i;
		check_eq(16'(wr_cnt), 16'(exp_n), "memory write count");
		for (i = 0; i < exp_n && i < wr_cnt; i++) begin
			check_eq(wr_addr_log[i], exp_wa[i], "write address");
			check_eq(16'(wr_data_log[i]), 16'(exp_wd[i]), "write data");
		end
	endtask

	task automatic check_next_fetch(input logic [15:0] from, input logic [15:0] to);
		int k;
		bit found;
		found = 0;
		for (k = 0; k + 1 < fetch_cnt && !found; k++)
			if (fetch_log[k] == from) begin
				found = 1;
				check_eq(fetch_log[k + 1], to, "fetch address after jump");
			end
		if (!found) begin
			$display("jump opcode at %h was never fetched or was the last fetch", from);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt != errs_before)
			fail_cnt++;
		$display("test %s: %s", name, (err_cnt == errs_before) ? "ok" : "FAILED");
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic reset_test();
		int e;
		e = err_cnt;
		begin_prog();
		emit(8'h00);
		emit(8'h00);
		emit(8'h76);
		run_prog();
		check_eq(fetch_log[0], 16'h0000, "first fetch address");
		check_eq(16'(first_stat), 16'(cpu_pkg::STAT_OF), "first cycle status");
		check_eq(16'(fetch_cnt), 16'd3, "fetch count");
		finish_test("reset", e);
	endtask

	task automatic move_test();
		int e;
		logic [7:0] v1, v2, v3;
		e = err_cnt;
		v1 = rand_bits(8);
		v2 = rand_bits(8);
		v3 = rand_bits(8);
		begin_prog();
		mem[8'hF1] = v3;
		emit_mvi(4, 8'h00); // h
		emit_mvi(5, 8'hF0); // l
		emit_mvi(0, v1);
		emit(8'h48); // mov c,b
		emit(8'h51); // mov d,c
		emit(8'h7A); // mov a,d
		emit(8'h77); // mov m,a
		expect_write(16'h00F0, v1);
		emit_mvi(5, 8'hF1);
		emit(8'h5E); // mov e,m
		emit_mvi(5, 8'hF2);
		emit(8'h73); // mov m,e
		expect_write(16'h00F2, v3);
		emit(8'h36); // mvi m
		emit(v2);
		expect_write(16'h00F2, v2);
		emit(8'h76);
		run_prog();
		check_writes();
		finish_test("moves", e);
	endtask

	task automatic alu_test(input bit waits, input string name);
		int e, i;
		logic [7:0] a, f, h;
		logic [15:0] r;
		e = err_cnt;
		begin_prog();
		mem[8'hF9] = alu_c;
		a = alu_a0;
		f = 8'h00; // flags clear after reset
		h = 8'hB4; // m page differs from the fetch page
		emit_mvi(7, a);
		emit_mvi(4, h);
		for (i = 0; i < 8; i++) begin
			emit_mvi(5, 8'hF8);
			emit_mvi(0, alu_b[i]);
			emit(8'(8'h80 + i * 8)); // alu op b
			r = ref_alu(i, a, alu_b[i], f, 0);
			{f, a} = r;
			emit(8'h77);
			expect_write({h, 8'hF8}, a);
			emit_mvi(5, 8'hF9);
			emit(8'(8'h86 + i * 8)); // alu op m
			r = ref_alu(i, a, alu_c, f, 0);
			{f, a} = r;
			emit_mvi(5, 8'hF8);
			emit(8'h77);
			expect_write({h, 8'hF8}, a);
			emit(8'(8'hC6 + i * 8)); // immediate form
			emit(alu_d[i]);
			r = ref_alu(i, a, alu_d[i], f, 0);
			{f, a} = r;
			emit(8'h77);
			expect_write({h, 8'hF8}, a);
		end
		emit(8'h3C); // inr a
		r = ref_alu(0, a, 8'd1, f, 1);
		{f, a} = r;
		emit(8'h77);
		expect_write({h, 8'hF8}, a);
		emit(8'h3D); // dcr a
		r = ref_alu(2, a, 8'd1, f, 1);
		{f, a} = r;
		emit(8'h77);
		expect_write({h, 8'hF8}, a);
		emit(8'h76);
		wait_en = waits;
		run_prog();
		check_writes();
		if (waits && wait_total == 0) begin
			$display("no READY wait state was inserted during the run");
			err_cnt++;
		end
		finish_test(name, e);
	endtask

	task automatic jump_test();
		int e, ccc, op;
		logic [7:0] a, b, f, p;
		logic [15:0] r;
		logic [15:0] jfrom [0:8];
		logic [15:0] jto [0:8];
		e = err_cnt;
		begin_prog();
		f = 8'h00;
		emit(8'hC3); // jmp 0008
		emit(8'h08);
		emit(8'h00);
		jfrom[0] = 16'h0000;
		jto[0] = 16'h0008;
		prog_ptr = 8'h08;
		for (ccc = 0; ccc < 8; ccc++) begin
			a = rand_bits(8);
			b = rand_bits(8);
			op = int'(rand_bits(3));
			emit_mvi(7, a);
			emit_mvi(0, b);
			emit(8'(8'h80 + op * 8));
			r = ref_alu(op, a, b, f, 0);
			f = r[15:8];
			p = prog_ptr;
			emit(8'(8'hC2 + ccc * 8)); // jccc past the nop
			emit(p + 8'd4);
			emit(8'h00);
			emit(8'h00);
			jfrom[ccc + 1] = {8'h00, p};
			jto[ccc + 1] = {8'h00, cond_holds(ccc, f) ? p + 8'd4 : p + 8'd3};
		end
		emit(8'h76);
		run_prog();
		for (ccc = 0; ccc < 9; ccc++)
			check_next_fetch(jfrom[ccc], jto[ccc]);
		finish_test("jumps", e);
	endtask

	task automatic halt_test();
		int e;
		e = err_cnt;
		begin_prog();
		emit_mvi(7, 8'h5A);
		emit(8'h76);
		emit(8'h00); // must never be fetched
		run_prog();
		check_eq(16'(fetch_cnt), 16'd2, "fetches before halt");
		finish_test("halt", e);
	endtask

	initial begin
		int i;
		clk = 1'b0;
		rst = 1'b1;
		i_ready = 1'b1;
		i_ad = 8'h00;
		wait_en = 1'b0;
		wait_left = 0;
		prev_rd = 1'b1;
		prev_wr = 1'b1;
		lfsr_q = 32'd84014;
		err_cnt = 0;
		test_cnt = 0;
		fail_cnt = 0;
		alu_a0 = rand_bits(8);
		alu_c = rand_bits(8);
		for (i = 0; i < 8; i++) begin
			alu_b[i] = rand_bits(8);
			alu_d[i] = rand_bits(8);
		end
		reset_test();
		move_test();
		alu_test(1'b0, "alu");
		jump_test();
		alu_test(1'b1, "alu with waits");
		halt_test();
		$display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
